// ==== files.f ====
source/organ_pkg.sv
source/control_pkg.sv
source/tick_generator.sv
source/tone_generator.sv
source/note_label.sv
source/speed_control.sv
source/seg7_display.sv
source/basic_organ.sv
tests/basic_organ_sva.sv
tests/tb_basic_organ.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_basic_organ \
    -f files.f -o sim_basic_organ &&
  ./obj_dir/sim_basic_organ ||
  { echo "Simulation did not pass"; exit 1; }

// ==== tests/tb_basic_organ.sv ====
`timescale 1ns/1ps

module tb_basic_organ;

  localparam int KEY_TICK    = 10;
  localparam int REFRESH     = 40;
  // Cycles between two repeats of a held key
  localparam int REPEAT_SPAN = 101 * KEY_TICK;
  localparam int PRESS_PHASE = 300;
  localparam int EXTRA_MAX   = 600;
  localparam int SETTLE      = REFRESH + 8;
  localparam int WORST_HALF  = 47800;
  localparam int NUM_STEPS   = 13;

  typedef struct packed {
    logic [2:0]  note;
    logic        tone_en;
    logic        up_n;
    logic        down_n;
    logic        clear_n;
    logic [31:0] repeats;
    logic [31:0] wait_cycles;
    logic [31:0] name;
    logic [31:0] half_period;
    logic [15:0] count;
  } step_t;

  // Active-low patterns for 0 to F with bit 0 as segment a
  localparam logic [6:0] SEG_TABLE [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M;
  logic        reset;
  logic [2:0]  note_sel;
  logic        tone_enable;
  logic        key_up_n;
  logic        key_down_n;
  logic        key_clear_n;
  logic [7:0]  audio_sample;
  logic [31:0] note_name;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;
  logic [41:0] hex_bus;
  step_t       steps [NUM_STEPS];
  int          seed;
  int          cyc;

  assign hex_bus = {hex5, hex4, hex3, hex2, hex1, hex0};

  basic_organ #(
    .key_tick_period (KEY_TICK),
    .refresh_period  (REFRESH)
  ) i_basic_organ (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .note_sel     (note_sel),
    .tone_enable  (tone_enable),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_clear_n  (key_clear_n),
    .audio_sample (audio_sample),
    .note_name    (note_name),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  always #10 CLK_50M = ~CLK_50M;

  // Cycles since reset release give the phase of the key repeat
  always @(posedge CLK_50M)
  begin
    if (reset)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  // ====================================================================
  // Step table
  // ====================================================================
  task automatic load_steps();
    // note, tone, up_n, down_n, clear_n, repeats, wait, name, half period, count
    steps[0]  = '{3'd0, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Do  ", 32'd47800, 16'd12499};
    steps[1]  = '{3'd1, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Re  ", 32'd42590, 16'd12499};
    steps[2]  = '{3'd2, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Mi  ", 32'd37936, 16'd12499};
    steps[3]  = '{3'd3, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Fa  ", 32'd35817, 16'd12499};
    steps[4]  = '{3'd4, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "So  ", 32'd31929, 16'd12499};
    steps[5]  = '{3'd5, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "La  ", 32'd28409, 16'd12499};
    steps[6]  = '{3'd6, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Si  ", 32'd25329, 16'd12499};
    steps[7]  = '{3'd7, 1'b1, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Do2 ", 32'd23900, 16'd12499};
    // Muted Fa
    steps[8]  = '{3'd3, 1'b0, 1'b1, 1'b1, 1'b1, 32'd0, SETTLE, "Fa  ", 32'd35817, 16'd12499};
    steps[9]  = '{3'd4, 1'b1, 1'b0, 1'b1, 1'b1, 32'd2, SETTLE, "So  ", 32'd0, 16'd12699};
    // Up wins when up and down are held together
    steps[10] = '{3'd4, 1'b1, 1'b0, 1'b0, 1'b1, 32'd1, SETTLE, "So  ", 32'd0, 16'd12799};
    steps[11] = '{3'd4, 1'b1, 1'b1, 1'b0, 1'b1, 32'd1, SETTLE, "So  ", 32'd0, 16'd12699};
    steps[12] = '{3'd4, 1'b1, 1'b1, 1'b1, 1'b0, 32'd0, SETTLE, "So  ", 32'd0, 16'd12499};
  endtask

  function automatic int step_cycles(input step_t s);
    // Two measured levels, key hold with phase alignment, display wait
    return 2 * s.half_period + (s.repeats + 1) * REPEAT_SPAN + EXTRA_MAX
           + s.wait_cycles + 4;
  endfunction

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic compare_digits(input logic [15:0] count);
    logic [23:0] value;
    value = {8'h00, count};
    for (int d = 0; d < 6; d++)
      check_value({25'd0, hex_bus[7*d +: 7]}, {25'd0, SEG_TABLE[value[4*d +: 4]]},
                  $sformatf("hex%0d segments", d));
  endtask

  // Timing starts at the first toggle after the select
  task automatic measure_tone(input logic [31:0] half);
    logic [7:0]  level;
    logic [7:0]  first_level;
    logic [31:0] len;
    level = audio_sample;
    first_level = 8'h00;
    while (audio_sample == level)
      @(negedge CLK_50M);
    for (int k = 0; k < 2; k++)
    begin
      level = audio_sample;
      if (k == 0)
      begin
        first_level = level;
        check_value(level == 8'h7F || level == 8'h80, 1, "tone level");
      end
      else
        check_value(level, (first_level == 8'h7F) ? 8'h80 : 8'h7F, "second tone level");
      len = 0;
      while (audio_sample == level)
      begin
        len++;
        @(negedge CLK_50M);
      end
      check_value(len, half, "half period length");
    end
  endtask

  task automatic expect_silence(input logic [31:0] half);
    for (int k = 0; k < half; k++)
    begin
      @(negedge CLK_50M);
      check_value(audio_sample, 8'h80, "muted sample");
    end
  endtask

  task automatic press_keys(input step_t s);
    int extra;
    if (!s.clear_n)
    begin
      key_clear_n = 1'b0;
      repeat (4) @(negedge CLK_50M);
      key_clear_n = 1'b1;
    end
    else if (!s.up_n || !s.down_n)
    begin
      // Press far from the repeat instant so the number of repeats is fixed
      while (cyc % REPEAT_SPAN != PRESS_PHASE)
        @(negedge CLK_50M);
      extra = $unsigned($random(seed)) % EXTRA_MAX;
      key_up_n   = s.up_n;
      key_down_n = s.down_n;
      repeat (s.repeats * REPEAT_SPAN + extra) @(negedge CLK_50M);
      key_up_n   = 1'b1;
      key_down_n = 1'b1;
    end
  endtask

  task automatic run_step(input step_t s);
    note_sel    = s.note;
    tone_enable = s.tone_en;
    @(posedge CLK_50M);
    check_value(note_name, s.name, "note name");
    @(negedge CLK_50M);
    if (s.half_period != 0)
    begin
      if (s.tone_en)
        measure_tone(s.half_period);
      else
        expect_silence(s.half_period);
    end
    press_keys(s);
    repeat (s.wait_cycles) @(negedge CLK_50M);
    compare_digits(s.count);
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial
  begin
    seed        = 87349;
    CLK_50M     = 1'b0;
    reset       = 1'b1;
    note_sel    = 3'd0;
    tone_enable = 1'b0;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_clear_n = 1'b1;
    load_steps();
    repeat (10) @(negedge CLK_50M);
    reset = 1'b0;
    // All zeros first, then 0030D3 after one refresh
    @(negedge CLK_50M);
    compare_digits(16'h0000);
    repeat (REFRESH + 2) @(negedge CLK_50M);
    compare_digits(16'd12499);
    for (int i = 0; i < NUM_STEPS; i++)
      run_step(steps[i]);
    $display("All tests passed!");
    $finish;
  end

  initial
  begin : watchdog
    int budget;
    @(negedge reset);
    budget = 8 * WORST_HALF + 10000;
    for (int i = 0; i < NUM_STEPS; i++)
      budget += step_cycles(steps[i]);
    repeat (budget) @(posedge CLK_50M);
    $display("Timeout: the test sequence did not finish in time");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== tests/basic_organ_sva.sv ====
`timescale 1ns/1ps

module basic_organ_sva #(
  parameter bit tone_checks = 1'b1
) (
  input logic                             CLK_50M,
  input logic                             reset,
  input logic [organ_pkg::SAMPLE_W-1:0]   audio_sample,
  input logic                             tone_enable,
  input logic [control_pkg::SPEED_W-1:0]  speed_offset
);

  localparam logic [control_pkg::SPEED_W-1:0] STEP = control_pkg::SPEED_STEP;

  if (tone_checks)
  begin : g_tone
    // Only the two square-wave levels reach the output
    sample_levels: assert property (@(posedge CLK_50M) disable iff (reset)
      audio_sample == organ_pkg::SAMPLE_HIGH || audio_sample == organ_pkg::SAMPLE_LOW)
      else $error("audio sample is neither the high nor the low level");

    mute_low: assert property (@(posedge CLK_50M) disable iff (reset)
      !tone_enable |-> audio_sample == organ_pkg::SAMPLE_LOW)
      else $error("muted tone does not give the low level");
  end
  else
  begin : g_speed
    // One step up, one step down, or cleared
    offset_step: assert property (@(posedge CLK_50M) disable iff (reset)
      speed_offset != $past(speed_offset) |->
        speed_offset == $past(speed_offset) + STEP ||
        speed_offset == $past(speed_offset) - STEP ||
        speed_offset == '0)
      else $error("speed offset moved by something other than one step");
  end

endmodule

bind tone_generator basic_organ_sva #(.tone_checks(1'b1)) i_tone_sva (
  .CLK_50M      (CLK_50M),
  .reset        (reset),
  .audio_sample (audio_sample),
  .tone_enable  (tone_enable),
  .speed_offset ({control_pkg::SPEED_W{1'b0}})
);

bind speed_control basic_organ_sva #(.tone_checks(1'b0)) i_speed_sva (
  .CLK_50M      (CLK_50M),
  .reset        (reset),
  .audio_sample (organ_pkg::SAMPLE_LOW),
  .tone_enable  (1'b0),
  .speed_offset (speed_offset)
);

// ==== source/basic_organ.sv ====
`timescale 1ns/1ps

module basic_organ #(
  parameter int key_tick_period = control_pkg::KEY_TICK_PERIOD,
  parameter int refresh_period  = control_pkg::REFRESH_PERIOD
) (
  input  logic                            CLK_50M,
  input  logic                            reset,
  input  logic [2:0]                      note_sel,
  input  logic                            tone_enable,
  input  logic                            key_up_n,
  input  logic                            key_down_n,
  input  logic                            key_clear_n,
  output logic [organ_pkg::SAMPLE_W-1:0]  audio_sample,
  output logic [organ_pkg::NAME_W-1:0]    note_name,
  output logic [control_pkg::SEG_W-1:0]   hex0,
  output logic [control_pkg::SEG_W-1:0]   hex1,
  output logic [control_pkg::SEG_W-1:0]   hex2,
  output logic [control_pkg::SEG_W-1:0]   hex3,
  output logic [control_pkg::SEG_W-1:0]   hex4,
  output logic [control_pkg::SEG_W-1:0]   hex5
);

  logic                            key_tick;
  logic                            refresh_tick;
  logic [control_pkg::SPEED_W-1:0] sample_count;

  // ====================================================================
  // Tick enables
  // ====================================================================
  tick_generator #(.period(key_tick_period)) u_key_tick (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .tick    (key_tick)
  );

  tick_generator #(.period(refresh_period)) u_refresh_tick (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .tick    (refresh_tick)
  );

  // ====================================================================
  // Tone path
  // ====================================================================
  tone_generator u_tone (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .note_sel     (organ_pkg::note_t'(note_sel)),
    .tone_enable  (tone_enable),
    .audio_sample (audio_sample)
  );

  note_label u_label (
    .note_sel  (organ_pkg::note_t'(note_sel)),
    .note_name (note_name)
  );

  // ====================================================================
  // Speed keys and display
  // ====================================================================
  speed_control u_speed (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .key_tick     (key_tick),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_clear_n  (key_clear_n),
    .sample_count (sample_count)
  );

  seg7_display u_display (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .refresh_tick (refresh_tick),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

// ==== source/seg7_display.sv ====
`timescale 1ns/1ps

module seg7_display (
  input  logic                             CLK_50M,
  input  logic                             reset,
  input  logic                             refresh_tick,
  input  logic [control_pkg::SPEED_W-1:0]  sample_count,
  output logic [control_pkg::SEG_W-1:0]    hex0,
  output logic [control_pkg::SEG_W-1:0]    hex1,
  output logic [control_pkg::SEG_W-1:0]    hex2,
  output logic [control_pkg::SEG_W-1:0]    hex3,
  output logic [control_pkg::SEG_W-1:0]    hex4,
  output logic [control_pkg::SEG_W-1:0]    hex5
);

  logic [control_pkg::DIGITS-1:0][3:0] shown_count;

  // Active low, bit 0 is segment a
  function automatic logic [control_pkg::SEG_W-1:0] hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Count only moves to the digits on a refresh tick
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      shown_count <= '0;
    else if (refresh_tick)
      shown_count <= {{(control_pkg::DIGITS * 4 - control_pkg::SPEED_W){1'b0}}, sample_count};
  end

  assign hex0 = hex_to_seg(shown_count[0]);
  assign hex1 = hex_to_seg(shown_count[1]);
  assign hex2 = hex_to_seg(shown_count[2]);
  assign hex3 = hex_to_seg(shown_count[3]);
  assign hex4 = hex_to_seg(shown_count[4]);
  assign hex5 = hex_to_seg(shown_count[5]);

endmodule

// ==== source/speed_control.sv ====
`timescale 1ns/1ps

module speed_control (
  input  logic                             CLK_50M,
  input  logic                             reset,
  input  logic                             key_tick,
  input  logic                             key_up_n,
  input  logic                             key_down_n,
  input  logic                             key_clear_n,
  output logic [control_pkg::SPEED_W-1:0]  sample_count
);

  // Bit 0 up, bit 1 down, bit 2 clear, all active high after sync
  logic [2:0]                               key_meta;
  logic [2:0]                               key_sync;
  logic [$bits(control_pkg::REPEAT_TICKS)-1:0] repeat_cnt;
  logic                                     repeat_due;
  control_pkg::key_action_t                 action;
  logic signed [control_pkg::SPEED_W-1:0]   speed_offset;

  // Two-flop synchronizer on the inverted keys
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~{key_clear_n, key_down_n, key_up_n};
      key_sync <= key_meta;
    end
  end

  // ====================================================================
  // Repeat rate for held keys
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      repeat_cnt <= '0;
      repeat_due <= 1'b0;
    end
    else
    begin
      repeat_due <= 1'b0;
      if (key_tick)
      begin
        if (repeat_cnt == control_pkg::REPEAT_TICKS)
        begin
          repeat_cnt <= '0;
          repeat_due <= 1'b1;
        end
        else
          repeat_cnt <= repeat_cnt + 1'b1;
      end
    end
  end

  // Clear wins over up, up wins over down
  always_comb
  begin
    if (key_sync[2])
      action = control_pkg::act_clear;
    else if (repeat_due && key_sync[0])
      action = control_pkg::act_up;
    else if (repeat_due && key_sync[1])
      action = control_pkg::act_down;
    else
      action = control_pkg::act_none;
  end

  // ====================================================================
  // Offset and sampling count
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      speed_offset <= '0;
    else
    begin
      case (action)
        control_pkg::act_clear: speed_offset <= '0;
        control_pkg::act_up:    speed_offset <= speed_offset + control_pkg::SPEED_STEP;
        control_pkg::act_down:  speed_offset <= speed_offset - control_pkg::SPEED_STEP;
        default:                speed_offset <= speed_offset;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      sample_count <= control_pkg::DEFAULT_SAMPLE_COUNT;
    else
      sample_count <= control_pkg::DEFAULT_SAMPLE_COUNT + speed_offset;
  end

endmodule

// ==== source/note_label.sv ====
`timescale 1ns/1ps

module note_label (
  input  organ_pkg::note_t              note_sel,
  output logic [organ_pkg::NAME_W-1:0]  note_name
);

  // Same select as the tone divisor
  always_comb
  begin
    case (note_sel)
      organ_pkg::do_low:  note_name = organ_pkg::NOTE_NAME[0];
      organ_pkg::re:      note_name = organ_pkg::NOTE_NAME[1];
      organ_pkg::mi:      note_name = organ_pkg::NOTE_NAME[2];
      organ_pkg::fa:      note_name = organ_pkg::NOTE_NAME[3];
      organ_pkg::so:      note_name = organ_pkg::NOTE_NAME[4];
      organ_pkg::la:      note_name = organ_pkg::NOTE_NAME[5];
      organ_pkg::si:      note_name = organ_pkg::NOTE_NAME[6];
      organ_pkg::do_high: note_name = organ_pkg::NOTE_NAME[7];
      default:            note_name = organ_pkg::NOTE_NAME[0];
    endcase
  end

endmodule

// ==== source/tone_generator.sv ====
`timescale 1ns/1ps

module tone_generator (
  input  logic                            CLK_50M,
  input  logic                            reset,
  input  organ_pkg::note_t                note_sel,
  input  logic                            tone_enable,
  output logic [organ_pkg::SAMPLE_W-1:0]  audio_sample
);

  logic [organ_pkg::DIVISOR_W-1:0] divisor;
  logic [organ_pkg::DIVISOR_W-1:0] count;
  organ_pkg::note_t                note_q;
  logic                            wave;

  assign divisor = organ_pkg::NOTE_DIVISOR[note_sel];

  // Previous note, to restart the half period on a change
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      note_q <= organ_pkg::do_low;
    else
      note_q <= note_sel;
  end

  // ====================================================================
  // Half-period counter and square wave
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count <= '0;
      wave  <= 1'b0;
    end
    else if (note_sel != note_q)
    begin
      // Level is kept, only the count starts over
      count <= '0;
    end
    else if (count == divisor - 1'b1)
    begin
      count <= '0;
      wave  <= ~wave;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // Mute acts at once on the output
  assign audio_sample = (wave && tone_enable) ? organ_pkg::SAMPLE_HIGH
                                              : organ_pkg::SAMPLE_LOW;

endmodule

// ==== source/tick_generator.sv ====
`timescale 1ns/1ps

module tick_generator #(
  parameter int period = control_pkg::KEY_TICK_PERIOD
) (
  input  logic CLK_50M,
  input  logic reset,
  output logic tick
);

  logic [31:0] count;

  // Down counter, one tick every period cycles
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count <= period - 1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= period - 1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// ==== source/control_pkg.sv ====
package control_pkg;

  // One action per cycle from the speed keys
  typedef enum logic [1:0] {
    act_none  = 2'd0,
    act_up    = 2'd1,
    act_down  = 2'd2,
    act_clear = 2'd3
  } key_action_t;

  localparam int SPEED_W = 16;

  localparam logic [SPEED_W-1:0] SPEED_STEP           = 16'd100;
  localparam logic [SPEED_W-1:0] DEFAULT_SAMPLE_COUNT = 16'd12499;

  // Key ticks between two repeats of a held key
  localparam logic [7:0] REPEAT_TICKS = 8'd100;

  // 1 kHz key tick and 2 Hz display refresh
  localparam int KEY_TICK_PERIOD = 50000;
  localparam int REFRESH_PERIOD  = 25000000;

  // Seven-segment bank
  localparam int DIGITS = 6;
  localparam int SEG_W  = 7;

endpackage

// ==== source/organ_pkg.sv ====
package organ_pkg;

  // ====================================================================
  // Note selection
  // ====================================================================

  // Switch code for each note, Do up to Do2
  typedef enum logic [2:0] {
    do_low  = 3'd0,
    re      = 3'd1,
    mi      = 3'd2,
    fa      = 3'd3,
    so      = 3'd4,
    la      = 3'd5,
    si      = 3'd6,
    do_high = 3'd7
  } note_t;

  localparam int DIVISOR_W = 32;

  // Half-period of each note in 50 MHz cycles
  localparam logic [DIVISOR_W-1:0] NOTE_DIVISOR [0:7] = '{
    32'd47800, 32'd42590, 32'd37936, 32'd35817,
    32'd31929, 32'd28409, 32'd25329, 32'd23900
  };

  // ====================================================================
  // Note names
  // ====================================================================

  localparam int CHAR_W = 8;
  localparam int NAME_W = 4 * CHAR_W;

  // First character sits in the top byte
  localparam logic [NAME_W-1:0] NOTE_NAME [0:7] = '{
    "Do  ", "Re  ", "Mi  ", "Fa  ",
    "So  ", "La  ", "Si  ", "Do2 "
  };

  // Signed 8-bit audio levels
  localparam int SAMPLE_W = 8;
  localparam logic [SAMPLE_W-1:0] SAMPLE_HIGH = 8'h7F;
  localparam logic [SAMPLE_W-1:0] SAMPLE_LOW  = 8'h80;

endpackage
